/* design/icache_pkg.sv */
package icache_pkg;

    // address split
    localparam int addr_w   = 32;
    localparam int data_w   = 32;
    localparam int tag_w    = 20;   // bits 31:12
    localparam int index_w  = 7;    // bits 11:5
    localparam int offset_w = 5;    // word select is 4:2
    localparam int bank_num = 8;
    localparam int set_num  = 128;
    localparam int tagv_w   = tag_w + 1;
    localparam int line_w   = bank_num * data_w;

    typedef logic [31:0]  bus32_t;
    typedef logic [255:0] bus256_t;

    typedef struct packed {
        logic [7:0] pause;
        logic       exception_flush;
    } ctrl_t;

    typedef struct packed {
        bus32_t          pc;
        logic            inst_en;
        logic            valid;
        logic [5:0]      exc;
        logic [5:0][6:0] exc_cause;
    } front_req_t;

    typedef struct packed {
        bus32_t          pc;
        bus32_t          inst;
        logic            valid;
        logic [5:0]      exc;
        logic [5:0][6:0] exc_cause;
        logic            stall;    // as seen by the instruction buffer
    } fetch_out_t;

    // modes 0..2 all invalidate both ways at the index
    typedef enum logic [1:0] {
        cacop_init_tag  = 2'd0,
        cacop_index_inv = 2'd1,
        cacop_hit_inv   = 2'd2,
        cacop_none      = 2'd3
    } cacop_mode_e;

    typedef struct packed {
        logic        en;
        cacop_mode_e mode;
        bus32_t      addr;
    } cacop_req_t;

    function automatic logic [index_w-1:0] addr_index(input bus32_t a);
        return a[offset_w +: index_w];
    endfunction

    function automatic logic [tag_w-1:0] addr_tag(input bus32_t a);
        return a[addr_w-1 -: tag_w];
    endfunction

endpackage

/* design/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram
    import icache_pkg::*;
#(
    parameter int width = 32
) (
    input  logic               clk,
    input  logic               ena_i,
    input  logic [3:0]         wea_i,
    input  logic [index_w-1:0] addra_i,
    input  logic [width-1:0]   dina_i,
    input  logic [index_w-1:0] addrb_i,
    output logic [width-1:0]   doutb_o
);

    logic [width-1:0] mem [set_num];

    always_ff @(posedge clk) begin
        if (ena_i) begin
            for (int i = 0; i < width; i++) begin
                if (wea_i[i/8])  // byte lane of this bit
                    mem[addra_i][i] <= dina_i[i];
            end
        end
        doutb_o <= mem[addrb_i];  // read-first on collision
    end

endmodule

/* design/icache_way.sv */
`timescale 1ns/1ps

module icache_way
    import icache_pkg::*;
(
    input  logic               clk,
    input  logic [index_w-1:0] rd_index_i,
    input  logic [index_w-1:0] wr_index_i,
    input  logic               we_i,
    input  logic               tagv_clear_i,
    input  bus256_t            line_i,
    input  logic [tag_w-1:0]   tag_i,
    input  logic [2:0]         word_sel_i,
    output logic               hit_o,
    output bus32_t             word_o
);

    bus32_t              bank_q [bank_num];
    logic [tagv_w-1:0]   tagv_q;
    logic [tagv_w-1:0]   tagv_d;
    logic                tagv_we;

    // one word of the line per bank
    for (genvar i = 0; i < bank_num; i++) begin : g_bank
        sdp_ram #(
            .width(data_w)
        ) u_bank (
            .clk     (clk),
            .ena_i   (we_i),
            .wea_i   (4'hf),
            .addra_i (wr_index_i),
            .dina_i  (line_i[i*data_w +: data_w]),
            .addrb_i (rd_index_i),
            .doutb_o (bank_q[i])
        );
    end

    assign tagv_we = we_i || tagv_clear_i;
    assign tagv_d  = tagv_clear_i ? '0 : {1'b1, tag_i};  // valid on top

    sdp_ram #(
        .width(tagv_w)
    ) u_tagv (
        .clk     (clk),
        .ena_i   (tagv_we),
        .wea_i   (4'hf),
        .addra_i (wr_index_i),
        .dina_i  (tagv_d),
        .addrb_i (rd_index_i),
        .doutb_o (tagv_q)
    );

    assign hit_o  = tagv_q[tagv_w-1] && (tagv_q[tag_w-1:0] == tag_i);
    assign word_o = bank_q[word_sel_i];

endmodule

/* design/icache_lru.sv */
`timescale 1ns/1ps

module icache_lru
    import icache_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [index_w-1:0] index_i,
    input  logic               hit_i,
    input  logic               hit_way_i,
    input  logic               refill_i,
    input  logic               refill_way_i,
    output logic               victim_o
);

    logic [set_num-1:0] lru_q;  // way to replace next

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (hit_i) begin
            lru_q[index_i] <= !hit_way_i;
        end else if (refill_i) begin
            lru_q[index_i] <= !refill_way_i;
        end
    end

    assign victim_o = lru_q[index_i];

endmodule

/* design/icache.sv */
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  ctrl_t      ctrl_i,
    input  logic       branch_flush_i,
    input  front_req_t req_i,
    input  logic       uncache_i,
    input  cacop_req_t cacop_i,
    output logic       stall_o,
    output fetch_out_t out_o,
    output logic       rd_req_o,
    output bus32_t     rd_addr_o,
    input  logic       ret_valid_i,
    input  bus256_t    ret_data_i,
    output logic       ucache_ren_o,
    output bus32_t     ucache_addr_o,
    input  logic       ucache_rvalid_i,
    input  bus32_t     ucache_rdata_i
);

    front_req_t         pre_req;
    logic               pre_uncache;
    logic               uncache_pend, miss_pend, cacop_pend, ignore_ret;
    logic               read_success, branch_flush_q, rst_hold;
    logic               flush, pause_flush, clear_stage, accept, outstanding;
    logic               cacop_active, real_ret_valid, real_ucache_rvalid;
    logic               lookup, hit_w0, hit_w1, hit, hit_fail, victim;
    logic               refill_w0, refill_w1;
    logic [index_w-1:0] ram_index, wr_index;
    logic [2:0]         word_sel;
    bus32_t             word_w0, word_w1, inst;

    assign pause_flush  = ctrl_i.pause[1] && !ctrl_i.pause[2];
    assign flush        = branch_flush_i || ctrl_i.exception_flush || pause_flush;
    assign clear_stage  = branch_flush_i || ctrl_i.exception_flush;
    assign cacop_active = cacop_i.en && (cacop_i.mode != cacop_none);

    // returns owed to a flushed fetch are dropped
    assign real_ret_valid     = ret_valid_i && !ignore_ret;
    assign real_ucache_rvalid = ucache_rvalid_i && !ignore_ret;

    assign outstanding = (miss_pend && !ret_valid_i) || (uncache_pend && !ucache_rvalid_i);
    assign accept      = !stall_o && !ctrl_i.pause[0] && !clear_stage && !outstanding;

    always_ff @(posedge clk) begin
        if (reset || clear_stage) begin
            pre_req     <= '0;
            pre_uncache <= 1'b0;
        end else if (accept) begin
            pre_req     <= req_i;
            pre_uncache <= uncache_i && req_i.inst_en;
        end
    end

    // held address while stalled or paused
    assign ram_index = (stall_o || ctrl_i.pause[0]) ? addr_index(pre_req.pc)
                                                    : addr_index(req_i.pc);
    assign wr_index  = cacop_active ? addr_index(cacop_i.addr) : addr_index(pre_req.pc);
    assign word_sel  = pre_req.pc[4:2];

    assign refill_w0 = miss_pend && real_ret_valid && !cacop_active && !victim;
    assign refill_w1 = miss_pend && real_ret_valid && !cacop_active && victim;

    icache_way u_way0 (
        .clk          (clk),
        .rd_index_i   (ram_index),
        .wr_index_i   (wr_index),
        .we_i         (refill_w0),
        .tagv_clear_i (cacop_active),
        .line_i       (ret_data_i),
        .tag_i        (addr_tag(pre_req.pc)),
        .word_sel_i   (word_sel),
        .hit_o        (hit_w0),
        .word_o       (word_w0)
    );

    icache_way u_way1 (
        .clk          (clk),
        .rd_index_i   (ram_index),
        .wr_index_i   (wr_index),
        .we_i         (refill_w1),
        .tagv_clear_i (cacop_active),
        .line_i       (ret_data_i),
        .tag_i        (addr_tag(pre_req.pc)),
        .word_sel_i   (word_sel),
        .hit_o        (hit_w1),
        .word_o       (word_w1)
    );

    assign lookup   = pre_req.inst_en && !pre_uncache;
    assign hit      = lookup && (hit_w0 || hit_w1);
    assign hit_fail = lookup && !hit_w0 && !hit_w1;

    icache_lru u_lru (
        .clk          (clk),
        .reset        (reset),
        .index_i      (addr_index(pre_req.pc)),
        .hit_i        (hit),
        .hit_way_i    (!hit_w0),  // way 0 wins if both
        .refill_i     (refill_w0 || refill_w1),
        .refill_way_i (refill_w1),
        .victim_o     (victim)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            miss_pend    <= 1'b0;
            uncache_pend <= 1'b0;
            ignore_ret   <= 1'b0;
            cacop_pend   <= 1'b0;
            read_success <= 1'b0;
        end else begin
            cacop_pend   <= cacop_active;
            read_success <= real_ret_valid;  // replay on filled RAM
            if (ret_valid_i)
                miss_pend <= 1'b0;
            else if (hit_fail && !read_success && !cacop_active && !flush && !ignore_ret)
                miss_pend <= 1'b1;
            if (accept && uncache_i && req_i.inst_en)
                uncache_pend <= 1'b1;
            else if (ucache_rvalid_i)
                uncache_pend <= 1'b0;
            if (flush && outstanding)
                ignore_ret <= 1'b1;
            else if (ret_valid_i || ucache_rvalid_i)
                ignore_ret <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        rst_hold       <= reset;
        branch_flush_q <= branch_flush_i;
    end

    assign stall_o = rst_hold || (!flush && (cacop_active || cacop_pend || ignore_ret
                     || (uncache_pend && !real_ucache_rvalid) || hit_fail || read_success));

    assign rd_req_o      = miss_pend;
    assign rd_addr_o     = pre_req.pc;
    assign ucache_ren_o  = uncache_pend;
    assign ucache_addr_o = pre_req.pc;

    always_comb begin
        if (branch_flush_q)
            inst = '0;
        else if (uncache_pend && real_ucache_rvalid)
            inst = ucache_rdata_i;
        else if (lookup && hit_w0)
            inst = word_w0;
        else if (lookup && hit_w1)
            inst = word_w1;
        else if (hit_fail && real_ret_valid)
            inst = ret_data_i[word_sel*data_w +: data_w];  // critical word
        else
            inst = '0;
    end

    // buffer register towards the instruction buffer
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_o       <= '0;
            out_o.stall <= 1'b1;
        end else begin
            out_o.pc        <= pre_req.pc;
            out_o.inst      <= inst;
            out_o.valid     <= pre_req.valid;
            out_o.exc       <= pre_req.exc;
            out_o.exc_cause <= pre_req.exc_cause;
            out_o.stall     <= stall_o;
        end
    end

endmodule

/* design/ifetch_top.sv */
`timescale 1ns/1ps

module ifetch_top
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // fetch unit and pipeline control
    input  front_req_t front_req_i,
    input  ctrl_t      ctrl_i,
    input  logic       branch_flush_i,
    input  logic       icache_uncache_i,
    input  cacop_req_t cacop_i,
    output logic       stall_o,
    output fetch_out_t fetch_out_o,
    // refill port
    output logic       rd_req_o,
    output bus32_t     rd_addr_o,
    input  logic       ret_valid_i,
    input  bus256_t    ret_data_i,
    // uncached port
    output logic       ucache_ren_o,
    output bus32_t     ucache_addr_o,
    input  logic       ucache_rvalid_i,
    input  bus32_t     ucache_rdata_i
);

    icache u_icache (
        .clk             (clk),
        .reset           (reset),
        .ctrl_i          (ctrl_i),
        .branch_flush_i  (branch_flush_i),
        .req_i           (front_req_i),
        .uncache_i       (icache_uncache_i),
        .cacop_i         (cacop_i),
        .stall_o         (stall_o),
        .out_o           (fetch_out_o),
        .rd_req_o        (rd_req_o),
        .rd_addr_o       (rd_addr_o),
        .ret_valid_i     (ret_valid_i),
        .ret_data_i      (ret_data_i),
        .ucache_ren_o    (ucache_ren_o),
        .ucache_addr_o   (ucache_addr_o),
        .ucache_rvalid_i (ucache_rvalid_i),
        .ucache_rdata_i  (ucache_rdata_i)
    );

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] delay_i,  // reply latency in cycles
    input  logic       rd_req_i,
    input  bus32_t     rd_addr_i,
    output logic       ret_valid_o,
    output bus256_t    ret_data_o,
    input  logic       ucache_ren_i,
    input  bus32_t     ucache_addr_i,
    output logic       ucache_rvalid_o,
    output bus32_t     ucache_rdata_o
);

    // word at byte address a holds a ^ 0x5a5a0000
    function automatic bus256_t line_at(input bus32_t addr);
        bus256_t line;
        for (int i = 0; i < bank_num; i++)
            line[i*data_w +: data_w] = {addr[31:5], 3'(i), 2'b00} ^ 32'h5a5a_0000;
        return line;
    endfunction

    initial begin : refill_port
        bus32_t addr;
        int     wait_n;
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        forever begin
            @(negedge clk);
            if (!reset && rd_req_i) begin
                addr   = rd_addr_i;  // cache may clear it on a flush
                wait_n = delay_i;
                repeat (wait_n) @(posedge clk);
                #2;
                ret_valid_o = 1'b1;
                ret_data_o  = line_at(addr);
                @(posedge clk);
                #2;
                ret_valid_o = 1'b0;
            end
        end
    end

    initial begin : uncached_port
        bus32_t addr;
        int     wait_n;
        ucache_rvalid_o = 1'b0;
        ucache_rdata_o  = '0;
        forever begin
            @(negedge clk);
            if (!reset && ucache_ren_i) begin
                addr   = ucache_addr_i;
                wait_n = delay_i;
                repeat (wait_n) @(posedge clk);
                #2;
                ucache_rvalid_o = 1'b1;
                ucache_rdata_o  = ~addr;
                @(posedge clk);
                #2;
                ucache_rvalid_o = 1'b0;
            end
        end
    end

endmodule

/* test/tb_ifetch.sv */
`timescale 1ns/1ps

module tb_ifetch
    import icache_pkg::*;
();

    localparam int max_cycles = 4000;  // about 650 worst case cycles for each of 6 tests

    logic        clk;
    logic        reset;
    front_req_t  front_req;
    ctrl_t       ctrl;
    logic        branch_flush;
    logic        icache_uncache;
    cacop_req_t  cacop;
    logic        stall;
    fetch_out_t  fetch_out;
    logic        rd_req, ret_valid, ucache_ren, ucache_rvalid;
    bus32_t      rd_addr, ucache_addr, ucache_rdata;
    bus256_t     ret_data;
    logic [2:0]  mem_delay;
    logic [15:0] lfsr;
    int          cycle_count, out_count, refill_count, ucache_count;
    bus32_t      out_pc, out_inst, refill_addr, ucache_seen_addr;
    logic [5:0]  out_exc;
    logic [5:0][6:0] out_exc_cause;
    logic        rd_req_prev, ucache_prev;

    ifetch_top dut (
        .clk              (clk),
        .reset            (reset),
        .front_req_i      (front_req),
        .ctrl_i           (ctrl),
        .branch_flush_i   (branch_flush),
        .icache_uncache_i (icache_uncache),
        .cacop_i          (cacop),
        .stall_o          (stall),
        .fetch_out_o      (fetch_out),
        .rd_req_o         (rd_req),
        .rd_addr_o        (rd_addr),
        .ret_valid_i      (ret_valid),
        .ret_data_i       (ret_data),
        .ucache_ren_o     (ucache_ren),
        .ucache_addr_o    (ucache_addr),
        .ucache_rvalid_i  (ucache_rvalid),
        .ucache_rdata_i   (ucache_rdata)
    );

    tb_mem_model mem (
        .clk             (clk),
        .reset           (reset),
        .delay_i         (mem_delay),
        .rd_req_i        (rd_req),
        .rd_addr_i       (rd_addr),
        .ret_valid_o     (ret_valid),
        .ret_data_o      (ret_data),
        .ucache_ren_i    (ucache_ren),
        .ucache_addr_i   (ucache_addr),
        .ucache_rvalid_o (ucache_rvalid),
        .ucache_rdata_o  (ucache_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        assert (got === expected)
        else fail_run($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    task automatic ensure(input logic cond, input string what);
        assert (cond === 1'b1)
        else fail_run(what);
    endtask

    // fibonacci taps at 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // request held until the cache takes it
    task automatic issue_fetch(input bus32_t pc, input logic uncached);
        logic taken;
        logic [1:0] r;
        @(posedge clk);
        #2;
        r[0] = lfsr_step();
        r[1] = lfsr_step();
        mem_delay           = 3'd3 + 3'(r);  // 3 to 6 cycles
        front_req.pc        = pc;
        front_req.inst_en   = 1'b1;
        front_req.valid     = 1'b1;
        front_req.exc       = pc[7:2];
        front_req.exc_cause = {6{pc[8:2]}};
        icache_uncache      = uncached;
        do begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
            #2;
        end while (!taken);
        front_req      = '0;
        icache_uncache = 1'b0;
    endtask

    task automatic fetch_and_check(input bus32_t pc, input logic miss, input logic uncached);
        int     outs, refills, ucaches;
        bus32_t expected;
        outs     = out_count;
        refills  = refill_count;
        ucaches  = ucache_count;
        issue_fetch(pc, uncached);
        while (out_count == outs)
            @(posedge clk);
        expected = uncached ? ~pc : pc ^ 32'h5a5a_0000;
        compare_value("fetch_out.pc", out_pc, pc);
        compare_value("fetch_out.inst", out_inst, expected);
        compare_value("fetch_out.exc", out_exc, pc[7:2]);
        compare_value("fetch_out.exc_cause", out_exc_cause, {6{pc[8:2]}});
        compare_value("rd_req_o rises", refill_count - refills, miss);
        compare_value("ucache_ren_o rises", ucache_count - ucaches, uncached);
        if (miss)
            compare_value("rd_addr_o", refill_addr, pc);
        if (uncached)
            compare_value("ucache_addr_o", ucache_seen_addr, pc);
    endtask

    task automatic invalidate_index(input cacop_mode_e mode, input bus32_t addr);
        @(posedge clk);
        #2;
        cacop.en   = 1'b1;
        cacop.mode = mode;
        cacop.addr = addr;
        @(posedge clk);
        #2;
        cacop = '{en: 1'b0, mode: cacop_none, addr: '0};
        do
            @(negedge clk);
        while (stall);
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (rd_req && !rd_req_prev) begin
                refill_count++;
                refill_addr = rd_addr;
            end
            if (ucache_ren && !ucache_prev) begin
                ucache_count++;
                ucache_seen_addr = ucache_addr;
            end
            if (fetch_out.valid && !fetch_out.stall) begin  // word taken by the buffer
                out_count++;
                out_pc        = fetch_out.pc;
                out_inst      = fetch_out.inst;
                out_exc       = fetch_out.exc;
                out_exc_cause = fetch_out.exc_cause;
            end
        end
        rd_req_prev = rd_req;
        ucache_prev = ucache_ren;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles)
            fail_run("timeout: the run did not finish within the cycle limit");
    end

    task automatic reset_and_clear();
        @(negedge clk);
        ensure(!rd_req, "rd_req_o is high after reset");
        ensure(!ucache_ren, "ucache_ren_o is high after reset");
        ensure(!fetch_out.valid, "fetch_out valid is high after reset");
        ensure(fetch_out.stall, "fetch_out stall is low after reset");
        for (int i = 0; i < set_num; i++)
            invalidate_index(cacop_init_tag, 32'(i) << offset_w);
    endtask

    task automatic miss_then_hit();
        bus32_t base;
        base = 32'h0000_1040;
        fetch_and_check(base + 32'h0c, 1'b1, 1'b0);  // critical word mid line
        for (int w = 0; w < bank_num; w++)
            fetch_and_check(base + 32'(4 * w), 1'b0, 1'b0);
    endtask

    // three tags on set 5
    task automatic lru_replacement();
        fetch_and_check(32'h0001_00a4, 1'b1, 1'b0);
        fetch_and_check(32'h0002_00a8, 1'b1, 1'b0);
        fetch_and_check(32'h0001_00a4, 1'b0, 1'b0);
        fetch_and_check(32'h0003_00ac, 1'b1, 1'b0);
        fetch_and_check(32'h0001_00a4, 1'b0, 1'b0);
        fetch_and_check(32'h0002_00a8, 1'b1, 1'b0);  // b was evicted by c
    endtask

    task automatic index_invalidate();
        invalidate_index(cacop_index_inv, 32'h0001_00a0);
        fetch_and_check(32'h0001_00a4, 1'b1, 1'b0);
        fetch_and_check(32'h0002_00a8, 1'b1, 1'b0);
    endtask

    task automatic uncached_fetch();
        fetch_and_check(32'h8000_0010, 1'b0, 1'b1);
        fetch_and_check(32'h8000_0010, 1'b0, 1'b1);
        fetch_and_check(32'h0000_1044, 1'b0, 1'b1);  // cached line bypassed
    endtask

    task automatic flush_during_miss();
        bus32_t pc_d;
        int     outs, refills;
        pc_d    = 32'h0004_0104;
        outs    = out_count;
        refills = refill_count;
        issue_fetch(pc_d, 1'b0);
        while (refill_count == refills)
            @(posedge clk);
        #2;
        branch_flush = 1'b1;
        @(negedge clk);
        ensure(!stall, "stall stayed high during the branch flush");
        @(posedge clk);
        #2;
        branch_flush = 1'b0;
        do
            @(negedge clk);
        while (rd_req || stall);  // wait out the dropped return
        @(posedge clk);
        compare_value("outputs of flushed fetch", out_count - outs, 0);
        fetch_and_check(32'h0005_0128, 1'b1, 1'b0);
        fetch_and_check(pc_d, 1'b1, 1'b0);  // dropped line was never written
    endtask

    initial begin
        lfsr           = 16'd29;
        reset          = 1'b1;
        front_req      = '0;
        ctrl           = '0;
        branch_flush   = 1'b0;
        icache_uncache = 1'b0;
        cacop          = '{en: 1'b0, mode: cacop_none, addr: '0};
        mem_delay      = 3'd3;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        reset_and_clear();
        miss_then_hit();
        lru_replacement();
        index_invalidate();
        uncached_fetch();
        flush_during_miss();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
design/icache_pkg.sv
design/sdp_ram.sv
design/icache_way.sv
design/icache_lru.sv
design/icache.sv
design/ifetch_top.sv
test/tb_mem_model.sv
test/tb_ifetch.sv

/* Bender.yml */
package:
  name: ifetch_icache

sources:
  - design/icache_pkg.sv
  - design/sdp_ram.sv
  - design/icache_way.sv
  - design/icache_lru.sv
  - design/icache.sv
  - design/ifetch_top.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_ifetch.sv
